// File: source/fzr_alu.sv
// ------------------------------------------------
// fzr alu
// chunk-serial add / sub with a carry linking the
// chunks, plus xor, or and and
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fzr_settings.svh"

module fzr_alu (
  input  logic               clk_i,
  input  fzr_pkg::cntrl_t    cntrl_i,
  input  fzr_pkg::id_ctrl_t  ctrl_i,
  input  fzr_pkg::chunk_t    rs_a_i,
  input  fzr_pkg::chunk_t    rs_b_i,
  output fzr_pkg::chunk_t    res_o
);

  fzr_pkg::chunk_t      a;
  fzr_pkg::chunk_t      b;
  logic                 cin;
  logic                 carry_q;
  logic [`FZR_CHUNK:0]  sum;

  // operand a is zero for lui
  assign a   = ctrl_i.en_a ? rs_a_i : '0;
  // two's complement subtract, invert b and add one on the first chunk
  assign b   = ctrl_i.op_sub ? ~rs_b_i : rs_b_i;
  assign cin = cntrl_i.lsb ? ctrl_i.op_sub : carry_q;
  assign sum = {1'b0, a} + {1'b0, b} + {{`FZR_CHUNK{1'b0}}, cin};

  // carry into the next chunk
  always_ff @(posedge clk_i) begin
    if (cntrl_i.exec) carry_q <= sum[`FZR_CHUNK];
  end

  always_comb begin
    if (ctrl_i.op_xor)      res_o = a ^ rs_b_i;
    else if (ctrl_i.op_or)  res_o = a | rs_b_i;
    else if (ctrl_i.op_and) res_o = a & rs_b_i;
    else                    res_o = sum[`FZR_CHUNK-1:0];
  end

endmodule

`default_nettype wire

// File: source/fzr_cntrl.sv
// ------------------------------------------------
// fzr control
// fetch / execute / store sequencing, chunk cycle
// counter and the incrementing program counter
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fzr_settings.svh"

module fzr_cntrl (
  input  logic                clk_i,
  input  logic                rst_in,
  input  logic                imem_ack_i,
  input  logic                dmem_ack_i,
  input  logic                is_store_i,
  output fzr_pkg::cntrl_t     cntrl_o,
  output logic                imem_stb_o,
  output logic                dmem_stb_o,
  output logic [31:0]         pc_o
);

  localparam int NCHUNK = `FZR_XLEN / `FZR_CHUNK;

  typedef enum logic [1:0] {
    S_FETCH,
    S_EXEC,
    S_STORE
  } state_t;

  state_t         state_q;
  state_t         state_d;
  fzr_pkg::icyc_t cnt_q;
  logic           exec;
  logic           last;
  logic           imem_stb_q;
  logic           dmem_stb_q;
  logic [31:0]    pc_q;

  assign exec = (state_q == S_EXEC);
  // final chunk of the word
  assign last = exec && (cnt_q == fzr_pkg::icyc_t'(NCHUNK - 1));

  // ------------------------------------------------
  // phase sequencing
  // ------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      // word arrives with the ack
      S_FETCH: if (imem_stb_o && imem_ack_i) state_d = S_EXEC;
      // after the last chunk, store or fetch the next word
      S_EXEC:  if (last) state_d = is_store_i ? S_STORE : S_FETCH;
      S_STORE: if (dmem_stb_o && dmem_ack_i) state_d = S_FETCH;
      default: state_d = S_FETCH;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q    <= S_FETCH;
      cnt_q      <= '0;
      imem_stb_q <= 1'b0;
      dmem_stb_q <= 1'b0;
      pc_q       <= `FZR_BOOT_ADR;
    end else begin
      state_q    <= state_d;
      // strobes follow the phase one cycle ahead, low in reset
      imem_stb_q <= (state_d == S_FETCH);
      dmem_stb_q <= (state_d == S_STORE);
      // counter wraps back to zero after the last chunk
      if (exec) cnt_q <= cnt_q + 1'b1;
      // next sequential word
      if (last) pc_q <= pc_q + 32'd4;
    end
  end

  assign imem_stb_o   = imem_stb_q;
  assign dmem_stb_o   = dmem_stb_q;
  assign pc_o         = pc_q;

  assign cntrl_o.exec = exec;
  assign cntrl_o.lsb  = exec && (cnt_q == '0);
  assign cntrl_o.msb  = last;
  assign cntrl_o.icyc = cnt_q;

  // each strobe drops right after its one-cycle ack
  assert property (@(posedge clk_i) disable iff (!rst_in)
    (imem_stb_o && imem_ack_i) |=> !imem_stb_o);

  assert property (@(posedge clk_i) disable iff (!rst_in)
    (dmem_stb_o && dmem_ack_i) |=> !dmem_stb_o);

  // every execute phase starts from chunk zero
  assert property (@(posedge clk_i) disable iff (!rst_in)
    !cntrl_o.exec |-> (cntrl_o.icyc == '0));

endmodule

`default_nettype wire

// File: source/fzr_core.sv
// ------------------------------------------------
// fzr core top level
// chunk-serial RV32I subset with an instruction
// port and a word store port, strobe / ack
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fzr_settings.svh"

module fzr_core (
  input  logic         clk_i,
  input  logic         rst_in,

  output logic         imem_stb_o,
  output logic [31:0]  imem_adr_o,
  input  logic [31:0]  imem_dat_i,
  input  logic         imem_ack_i,

  output logic         dmem_stb_o,
  output logic [31:0]  dmem_adr_o,
  output logic [31:0]  dmem_dat_o,
  input  logic         dmem_ack_i
);

  fzr_pkg::cntrl_t    cntrl;
  fzr_pkg::id_ctrl_t  id_ctrl;
  fzr_pkg::chunk_t    id_imm;
  fzr_pkg::chunk_t    rf_ra;
  fzr_pkg::chunk_t    rf_rb;
  fzr_pkg::chunk_t    ex_rb;
  fzr_pkg::chunk_t    ex_res;
  logic [31:0]        pc;

  // ------------------------------------------------
  // sequencing and fetch
  // ------------------------------------------------

  fzr_cntrl i_fzr_cntrl (
    .clk_i      ( clk_i            ),
    .rst_in     ( rst_in           ),
    .imem_ack_i ( imem_ack_i       ),
    .dmem_ack_i ( dmem_ack_i       ),
    .is_store_i ( id_ctrl.is_store ),
    .cntrl_o    ( cntrl            ),
    .imem_stb_o ( imem_stb_o       ),
    .dmem_stb_o ( dmem_stb_o       ),
    .pc_o       ( pc               )
  );

  assign imem_adr_o = {pc[31:2], 2'b00};

  fzr_decode i_fzr_decode (
    .clk_i   ( clk_i      ),
    .rst_in  ( rst_in     ),
    .instr_i ( imem_dat_i ),
    .load_i  ( imem_ack_i ),
    .cntrl_i ( cntrl      ),
    .ctrl_o  ( id_ctrl    ),
    .imm_o   ( id_imm     )
  );

  // ------------------------------------------------
  // execute
  // ------------------------------------------------

  // operand b, immediate for I, S and U formats
  assign ex_rb = id_ctrl.use_imm ? id_imm : rf_rb;

  fzr_regfile i_fzr_regfile (
    .clk_i   ( clk_i   ),
    .cntrl_i ( cntrl   ),
    .ctrl_i  ( id_ctrl ),
    .res_i   ( ex_res  ),
    .ra_o    ( rf_ra   ),
    .rb_o    ( rf_rb   )
  );

  fzr_alu i_fzr_alu (
    .clk_i   ( clk_i   ),
    .cntrl_i ( cntrl   ),
    .ctrl_i  ( id_ctrl ),
    .rs_a_i  ( rf_ra   ),
    .rs_b_i  ( ex_rb   ),
    .res_o   ( ex_res  )
  );

  // store address from the adder, data straight from rs2
  fzr_lsu i_fzr_lsu (
    .clk_i      ( clk_i            ),
    .cntrl_i    ( cntrl            ),
    .is_store_i ( id_ctrl.is_store ),
    .adr_ser_i  ( ex_res           ),
    .dat_ser_i  ( rf_rb            ),
    .adr_o      ( dmem_adr_o       ),
    .dat_o      ( dmem_dat_o       )
  );

endmodule

`default_nettype wire

// File: source/fzr_decode.sv
// ------------------------------------------------
// fzr decode
// captures the fetched word as decoded control and
// shifts the sign extended immediate out serially
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fzr_settings.svh"

module fzr_decode (
  input  logic               clk_i,
  input  logic               rst_in,
  input  fzr_pkg::instr_u    instr_i,
  input  logic               load_i,
  input  fzr_pkg::cntrl_t    cntrl_i,
  output fzr_pkg::id_ctrl_t  ctrl_o,
  output fzr_pkg::chunk_t    imm_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  fzr_pkg::id_ctrl_t     dec;
  fzr_pkg::id_ctrl_t     ctrl_q;
  logic [`FZR_XLEN-1:0]  imm_dec;
  logic [`FZR_XLEN-1:0]  imm_q;
  logic [2:0]            f3;
  logic                  f3_alu;

  assign f3     = instr_i.r_fmt.funct3;
  // add/sub, xor, or, and; shifts and compares are not built
  assign f3_alu = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);

  always_comb begin
    dec         = '0;
    dec.rs1     = instr_i.r_fmt.rs1;
    dec.rs2     = instr_i.r_fmt.rs2;
    dec.en_a    = 1'b1;
    imm_dec     = '0;
    case (instr_i.r_fmt.opcode)
      OPC_OP: if (f3_alu) begin
        dec.rd     = instr_i.r_fmt.rd;
        dec.rf_we  = 1'b1;
        dec.op_sub = (f3 == 3'b000) && instr_i.r_fmt.funct7[5];
        dec.op_xor = (f3 == 3'b100);
        dec.op_or  = (f3 == 3'b110);
        dec.op_and = (f3 == 3'b111);
      end
      OPC_OP_IMM: if (f3_alu) begin
        dec.rd      = instr_i.i_fmt.rd;
        dec.rf_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.op_xor  = (f3 == 3'b100);
        dec.op_or   = (f3 == 3'b110);
        dec.op_and  = (f3 == 3'b111);
        imm_dec = {{(`FZR_XLEN-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
      end
      OPC_LUI: begin
        // rd = 0 + imm, so operand a is masked
        dec.rd      = instr_i.u_fmt.rd;
        dec.rf_we   = 1'b1;
        dec.use_imm = 1'b1;
        dec.en_a    = 1'b0;
        imm_dec     = {instr_i.u_fmt.imm, 12'h000};
      end
      // word stores only, the adder forms rs1 + offset
      OPC_STORE: if (f3 == 3'b010) begin
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
        imm_dec = {{(`FZR_XLEN-12){instr_i.s_fmt.imm_hi[6]}},
                   instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
      end
      // anything else retires as a no-op
      default: ;
    endcase
  end

  // decoded control acts as the instruction register
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      ctrl_q <= '0;
    end else if (load_i) begin
      ctrl_q <= dec;
    end
  end

  // immediate, lowest chunk first
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      imm_q <= imm_dec;
    end else if (cntrl_i.exec) begin
      imm_q <= imm_q >> `FZR_CHUNK;
    end
  end

  assign ctrl_o = ctrl_q;
  assign imm_o  = imm_q[`FZR_CHUNK-1:0];

endmodule

`default_nettype wire

// File: source/fzr_lsu.sv
// ------------------------------------------------
// fzr store unit
// collects store address and data chunk by chunk
// into parallel words for the data port
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fzr_settings.svh"

module fzr_lsu (
  input  logic                  clk_i,
  input  fzr_pkg::cntrl_t       cntrl_i,
  input  logic                  is_store_i,
  input  fzr_pkg::chunk_t       adr_ser_i,
  input  fzr_pkg::chunk_t       dat_ser_i,
  output logic [`FZR_XLEN-1:0]  adr_o,
  output logic [`FZR_XLEN-1:0]  dat_o
);

  logic [`FZR_XLEN-1:0] adr_q;
  logic [`FZR_XLEN-1:0] dat_q;

  // new chunk enters at the top, after N shifts chunk 0 sits at the bottom
  always_ff @(posedge clk_i) begin
    if (cntrl_i.exec && is_store_i) begin
      adr_q <= {adr_ser_i, adr_q[`FZR_XLEN-1:`FZR_CHUNK]};
      dat_q <= {dat_ser_i, dat_q[`FZR_XLEN-1:`FZR_CHUNK]};
    end
  end

  // word aligned access only
  assign adr_o = {adr_q[`FZR_XLEN-1:2], 2'b00};
  assign dat_o = dat_q;

endmodule

`default_nettype wire

// File: source/fzr_pkg.sv
// ------------------------------------------------
// fzr shared types
// chunk, cycle index, instruction views and the
// decode and sequencing bundles
// ------------------------------------------------

`default_nettype none

`include "fzr_settings.svh"

package fzr_pkg;

  // one slice of the serial data path
  typedef logic [`FZR_CHUNK-1:0] chunk_t;

  // position of a chunk within a register
  typedef logic [$clog2(`FZR_XLEN/`FZR_CHUNK)-1:0] icyc_t;

  // register address
  typedef logic [$clog2(`FZR_NREGS)-1:0] radr_t;

  // one fetched word, read through each RV32I format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
  } instr_u;

  // decoded instruction, held for the whole instruction
  typedef struct packed {
    radr_t rs1;
    radr_t rs2;
    radr_t rd;
    logic  rf_we;
    logic  use_imm;
    logic  en_a;
    logic  op_sub;
    logic  op_xor;
    logic  op_or;
    logic  op_and;
    logic  is_store;
  } id_ctrl_t;

  // sequencing info for the chunk-serial datapath
  typedef struct packed {
    logic  exec;
    logic  lsb;
    logic  msb;
    icyc_t icyc;
  } cntrl_t;

endpackage

`default_nettype wire

// File: source/fzr_regfile.sv
// ------------------------------------------------
// fzr register file
// integer registers stored per chunk, read and
// written one chunk each execute cycle
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fzr_settings.svh"

module fzr_regfile (
  input  logic               clk_i,
  input  fzr_pkg::cntrl_t    cntrl_i,
  input  fzr_pkg::id_ctrl_t  ctrl_i,
  input  fzr_pkg::chunk_t    res_i,
  output fzr_pkg::chunk_t    ra_o,
  output fzr_pkg::chunk_t    rb_o
);

  localparam int NCHUNK = `FZR_XLEN / `FZR_CHUNK;

  // [register][chunk]
  fzr_pkg::chunk_t regs_q [`FZR_NREGS][NCHUNK];

  // x0 is never written, reads are forced to zero
  assign ra_o = (ctrl_i.rs1 == '0) ? '0 : regs_q[ctrl_i.rs1][cntrl_i.icyc];
  assign rb_o = (ctrl_i.rs2 == '0) ? '0 : regs_q[ctrl_i.rs2][cntrl_i.icyc];

  // chunk k is read and rewritten in the same cycle, so rd may equal rs1/rs2
  always_ff @(posedge clk_i) begin
    if (cntrl_i.exec && ctrl_i.rf_we && (ctrl_i.rd != '0)) begin
      regs_q[ctrl_i.rd][cntrl_i.icyc] <= res_i;
    end
  end

endmodule

`default_nettype wire

// File: source/fzr_settings.svh
// ------------------------------------------------
// fzr core settings
// data path chunk width, register geometry and the
// first address fetched after reset
// ------------------------------------------------

`ifndef FZR_SETTINGS_SVH
`define FZR_SETTINGS_SVH

// bits processed per clock, 1, 2, 4 or 8
`define FZR_CHUNK 4
// architectural register width
`define FZR_XLEN 32
// number of integer registers
`define FZR_NREGS 32
// first fetch address out of reset
`define FZR_BOOT_ADR 32'h0000_0000

`endif

// File: test/fzr_cases.txt
# I <instruction word, hex>            program in fetch order from address 0
# S <store address> <store data, hex>  expected stores in the order they occur
I 123450B7 # lui  x1, 0x12345
I 00102023 # sw   x1, 0(x0)
I FFF00113 # addi x2, x0, -1
I 00100193 # addi x3, x0, 1
I 00310233 # add  x4, x2, x3
I 403002B3 # sub  x5, x0, x3
I 10000313 # addi x6, x0, 0x100
I FE432E23 # sw   x4, -4(x6)
I 005323A3 # sw   x5, 7(x6)
I F0F0F3B7 # lui  x7, 0xf0f0f
I FF03C413 # xori x8, x7, -16
I 407404B3 # sub  x9, x8, x7
I 0083E533 # or   x10, x7, x8
I 0084F5B3 # and  x11, x9, x8
I 00A4C633 # xor  x12, x9, x10
I 80006693 # ori  x13, x0, -2048
I F004F713 # andi x14, x9, -256
I 05508013 # addi x0, x1, 0x55
I FFF70793 # addi x15, x14, -1
I 00932023 # sw   x9, 0(x6)
I 00A32423 # sw   x10, 8(x6)
I 00B32623 # sw   x11, 12(x6)
I 00C32823 # sw   x12, 16(x6)
I 00D32A23 # sw   x13, 20(x6)
I 00E32C23 # sw   x14, 24(x6)
I 00032E23 # sw   x0, 28(x6)
I 02F32023 # sw   x15, 32(x6)
I FE80AC23 # sw   x8, -8(x1)
S 00000000 12345000
S 000000FC 00000000
S 00000104 FFFFFFFF
S 00000100 1E1E1FF0
S 00000108 FFFFFFF0
S 0000010C 0E0E0FF0
S 00000110 E1E1E000
S 00000114 FFFFF800
S 00000118 1E1E1F00
S 0000011C 00000000
S 00000120 1E1E1EFF
S 12344FF8 0F0F0FF0

// File: test/tb_checker.sv
// ------------------------------------------------
// testbench checker
// follows fetch addresses and compares every store
// with the expected list from the cases file
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input  logic        clk_i,
  input  logic        rst_in,
  input  logic        imem_stb_i,
  input  logic [31:0] imem_adr_i,
  input  logic        imem_ack_i,
  input  logic        dmem_stb_i,
  input  logic [31:0] dmem_adr_i,
  input  logic [31:0] dmem_dat_i,
  input  logic        dmem_ack_i,
  output int          errors_o,
  output int          stores_o,
  output int          fetches_o,
  output int          expected_o
);

  logic [31:0] exp_adr_q [$];
  logic [31:0] exp_dat_q [$];
  logic [31:0] next_fetch;
  int          reset_edges;
  // pending transfers, request must stay put until ack
  logic        imem_wait;
  logic [31:0] imem_adr_q;
  logic        dmem_wait;
  logic [31:0] dmem_adr_q;
  logic [31:0] dmem_dat_q;

  // ------------------------------------------------
  // expected stores, S lines only
  // ------------------------------------------------

  initial begin : load_expected
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] d;
    errors_o    = 0;
    stores_o    = 0;
    fetches_o   = 0;
    expected_o  = 0;
    reset_edges = 0;
    next_fetch  = 32'h0000_0000;
    imem_wait   = 1'b0;
    dmem_wait   = 1'b0;
    fd = $fopen("test/fzr_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/fzr_cases.txt for the expected stores");
      errors_o = 1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h %h", tag, a, d);
        if (n == 3 && tag == "S") begin
          exp_adr_q.push_back(a);
          exp_dat_q.push_back(d);
        end
      end
      $fclose(fd);
      expected_o = exp_adr_q.size();
    end
  end

  // ------------------------------------------------
  // bus watch, sampled on the DUT clock edge
  // ------------------------------------------------

  always @(posedge clk_i) begin
    if (!rst_in) begin
      // first edge only clears the strobe registers
      if (reset_edges > 0 && (imem_stb_i !== 1'b0 || dmem_stb_i !== 1'b0)) begin
        $display("Error at %0t: strobe high during reset", $time);
        errors_o++;
      end
      reset_edges++;
      imem_wait = 1'b0;
      dmem_wait = 1'b0;
    end else begin
      if (imem_wait && (imem_stb_i !== 1'b1 || imem_adr_i !== imem_adr_q)) begin
        $display("Error at %0t: fetch request changed before ack", $time);
        errors_o++;
      end
      if (dmem_wait && (dmem_stb_i !== 1'b1 || dmem_adr_i !== dmem_adr_q ||
                        dmem_dat_i !== dmem_dat_q)) begin
        $display("Error at %0t: store request changed before ack", $time);
        errors_o++;
      end
      // pc only steps by one word
      if (imem_stb_i && imem_ack_i) begin
        if (imem_adr_i !== next_fetch) begin
          $display("Error at %0t: fetch from %h, expected %h", $time, imem_adr_i,
                   next_fetch);
          errors_o++;
        end
        next_fetch = next_fetch + 32'd4;
        fetches_o++;
      end
      if (dmem_stb_i && dmem_ack_i) begin
        if (stores_o < exp_adr_q.size()) begin
          if (dmem_adr_i !== exp_adr_q[stores_o] || dmem_dat_i !== exp_dat_q[stores_o]) begin
            $display("Error at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                     stores_o, dmem_dat_i, dmem_adr_i, exp_dat_q[stores_o],
                     exp_adr_q[stores_o]);
            errors_o++;
          end
        end else begin
          $display("extra store at %0t to address %h, only %0d stores expected", $time,
                   dmem_adr_i, exp_adr_q.size());
          errors_o++;
        end
        stores_o++;
      end
      imem_wait  = imem_stb_i && !imem_ack_i;
      imem_adr_q = imem_adr_i;
      dmem_wait  = dmem_stb_i && !dmem_ack_i;
      dmem_adr_q = dmem_adr_i;
      dmem_dat_q = dmem_dat_i;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// ------------------------------------------------
// testbench clock and reset
// 10 ns clock, reset low for two rising edges
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the DUT sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_top.sv
// ------------------------------------------------
// testbench top
// program memory from the cases file, both ports
// acked after a random delay, run with timeouts
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam int TIMEOUT = 5000;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic        clk;
  logic        rst_n;
  logic        imem_stb;
  logic [31:0] imem_adr;
  logic [31:0] imem_dat;
  logic        imem_ack;
  logic        dmem_stb;
  logic [31:0] dmem_adr;
  logic [31:0] dmem_dat;
  logic        dmem_ack;
  int          errors;
  int          stores;
  int          fetches;
  int          expected;
  logic [31:0] prog_q [$];

  tb_clock i_tb_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  fzr_core fzr_core_i (
    .clk_i      ( clk      ),
    .rst_in     ( rst_n    ),
    .imem_stb_o ( imem_stb ),
    .imem_adr_o ( imem_adr ),
    .imem_dat_i ( imem_dat ),
    .imem_ack_i ( imem_ack ),
    .dmem_stb_o ( dmem_stb ),
    .dmem_adr_o ( dmem_adr ),
    .dmem_dat_o ( dmem_dat ),
    .dmem_ack_i ( dmem_ack )
  );

  tb_checker i_tb_checker (
    .clk_i      ( clk      ),
    .rst_in     ( rst_n    ),
    .imem_stb_i ( imem_stb ),
    .imem_adr_i ( imem_adr ),
    .imem_ack_i ( imem_ack ),
    .dmem_stb_i ( dmem_stb ),
    .dmem_adr_i ( dmem_adr ),
    .dmem_dat_i ( dmem_dat ),
    .dmem_ack_i ( dmem_ack ),
    .errors_o   ( errors   ),
    .stores_o   ( stores   ),
    .fetches_o  ( fetches  ),
    .expected_o ( expected )
  );

  // I lines in fetch order, word n sits at address 4*n
  task automatic read_program(output int ok);
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] w;
    ok = 0;
    fd = $fopen("test/fzr_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h", tag, w);
        if (n == 2 && tag == "I") prog_q.push_back(w);
      end
      $fclose(fd);
      ok = (prog_q.size() > 0);
    end
  endtask

  // past the program the core runs addi x0,x0,0
  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    int unsigned idx;
    idx = adr >> 2;
    if (idx < prog_q.size()) begin
      return prog_q[idx];
    end else begin
      return NOP;
    end
  endfunction

  // ------------------------------------------------
  // memories, one transfer outstanding at a time
  // ------------------------------------------------

  initial begin : memory_model
    int unsigned delay;
    imem_ack = 1'b0;
    imem_dat = NOP;
    dmem_ack = 1'b0;
    void'($urandom(32'h0b348b3c));
    forever begin
      @(negedge clk);
      if (rst_n && (imem_stb === 1'b1 || dmem_stb === 1'b1)) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        if (imem_stb === 1'b1) begin
          imem_dat = fetch_word(imem_adr);
          imem_ack = 1'b1;
        end else begin
          dmem_ack = 1'b1;
        end
        // ack lasts exactly one cycle
        @(negedge clk);
        imem_ack = 1'b0;
        dmem_ack = 1'b0;
      end
    end
  end

  // ------------------------------------------------
  // run control
  // ------------------------------------------------

  initial begin : run
    int cycles;
    int fails;
    int ok;
    fails = 0;
    read_program(ok);
    if (!ok) begin
      $display("no program words could be read from test/fzr_cases.txt");
      fails++;
    end
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout, reset was never released");
      fails++;
    end
    cycles = 0;
    while (stores < expected && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (stores < expected) begin
      $display("timeout, %0d of %0d stores seen, the rest are missing", stores, expected);
      fails++;
    end
    // run past the program end so a stray store is still caught
    cycles = 0;
    while (fetches < prog_q.size() + 2 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (fetches < prog_q.size() + 2) begin
      $display("timeout, core stopped fetching after %0d words", fetches);
      fails++;
    end
    $display("fetches %0d, stores %0d of %0d, errors %0d", fetches, stores, expected,
             errors + fails);
    if (fails == 0 && errors == 0 && expected > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/fzr_pkg.sv
source/fzr_cntrl.sv
source/fzr_decode.sv
source/fzr_alu.sv
source/fzr_regfile.sv
source/fzr_lsu.sv
source/fzr_core.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv
